/* common/rv64_pkg.sv */
package rv64_pkg;

  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  // number of decoder control bits carried by the decode/execute register
  localparam int ctrl_w = 42;

  // ####################################################################
  // instruction word, one view per base format
  // ####################################################################

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

  // opcode bits 6..2, the low pair is 2'b11 for every 32-bit encoding
  localparam logic [4:0] op_load   = 5'b00000;
  localparam logic [4:0] op_store  = 5'b01000;
  localparam logic [4:0] op_imm    = 5'b00100;
  localparam logic [4:0] op_imm_w  = 5'b00110;
  localparam logic [4:0] op_reg    = 5'b01100;
  localparam logic [4:0] op_reg_w  = 5'b01110;
  localparam logic [4:0] op_lui    = 5'b01101;
  localparam logic [4:0] op_auipc  = 5'b00101;
  localparam logic [4:0] op_jal    = 5'b11011;
  localparam logic [4:0] op_jalr   = 5'b11001;
  localparam logic [4:0] op_branch = 5'b11000;
  localparam logic [4:0] op_system = 5'b11100;

endpackage

/* decoder/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
  input  rv64_pkg::inst_t inst,

  output logic       wb_en,
  output logic       wb_load,
  output logic       wb_pc,
  output logic       wb_alu,

  output logic       I_type,
  output logic       S_type,
  output logic       B_type,
  output logic       U_type,
  output logic       J_type,

  output logic       rs1_en,
  output logic       rs2_en,
  output logic       pc_en,
  output logic       imm_en,

  output logic       lgc_en,
  output logic [3:0] lgc_op,
  output logic       wlgc_en,
  output logic [4:0] wlgc_op,
  output logic       br_en,
  output logic [2:0] br_op,

  output logic       jal_en,
  output logic       jalr_en,

  output logic       lb,
  output logic       lh,
  output logic       lw,
  output logic       ld,
  output logic       lbu,
  output logic       lhu,
  output logic       lwu,
  output logic       sb,
  output logic       sh,
  output logic       sw,
  output logic       sd,

  output logic       ebreak
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       lui_g, auipc_g, load_g, store_g;
  logic       imm_op, imm_sh, reg_op, immw_op, immw_sh, regw_op, r_type;

  assign opcode = inst.r.opcode[6:2];
  assign funct3 = inst.r.funct3;
  assign alt    = inst.r.funct7[5];  // instruction bit 30 picks sub and sra

  // ####################################################################
  // instruction groups
  // ####################################################################

  assign lui_g   = (opcode == rv64_pkg::op_lui);
  assign auipc_g = (opcode == rv64_pkg::op_auipc);
  assign load_g  = (opcode == rv64_pkg::op_load);
  assign store_g = (opcode == rv64_pkg::op_store);
  assign jal_en  = (opcode == rv64_pkg::op_jal);
  assign jalr_en = (opcode == rv64_pkg::op_jalr);
  assign br_en   = (opcode == rv64_pkg::op_branch);

  // funct3 x01 marks the shifts, which take bit 30 from the immediate field
  assign imm_op  = (opcode == rv64_pkg::op_imm) && (funct3[1:0] != 2'b01);
  assign imm_sh  = (opcode == rv64_pkg::op_imm) && (funct3[1:0] == 2'b01);
  assign immw_op = (opcode == rv64_pkg::op_imm_w) && (funct3[1:0] != 2'b01);
  assign immw_sh = (opcode == rv64_pkg::op_imm_w) && (funct3[1:0] == 2'b01);
  assign reg_op  = (opcode == rv64_pkg::op_reg);
  assign regw_op = (opcode == rv64_pkg::op_reg_w);

  assign ebreak = (opcode == rv64_pkg::op_system) && (inst.r.funct7 == 7'd0) &&
                  (inst.r.rs2 == 5'd1);

  // format flags and operand enables
  assign I_type = jalr_en | load_g | imm_op | imm_sh | immw_op | immw_sh;
  assign S_type = store_g;
  assign B_type = br_en;
  assign U_type = lui_g | auipc_g;
  assign J_type = jal_en;
  assign r_type = reg_op | regw_op;

  assign rs1_en = I_type | S_type | B_type | r_type;
  assign rs2_en = S_type | B_type | r_type;
  assign pc_en  = auipc_g | jal_en;
  assign imm_en = I_type | S_type | U_type | J_type;

  // ####################################################################
  // ALU op codes
  // ####################################################################

  assign lgc_en  = imm_op | imm_sh | reg_op | lui_g | auipc_g | jal_en | jalr_en |
                   load_g | store_g;
  assign wlgc_en = immw_op | immw_sh | regw_op;
  assign br_op   = funct3;

  always_comb begin
    lgc_op = 4'b0000;  // plain add for auipc, jumps and address calculation
    if (lui_g)
      lgc_op = 4'b1111;
    else if (reg_op || imm_sh)
      lgc_op = {alt, funct3};
    else if (imm_op)
      lgc_op = {1'b0, funct3};
  end

  always_comb begin
    wlgc_op = 5'b00000;
    if (immw_op)
      wlgc_op = {2'b10, funct3};
    else if (immw_sh || regw_op)
      wlgc_op = {1'b1, alt, funct3};
  end

  // load and store widths, funct3 bit 2 is the unsigned load variant
  assign lb  = load_g && (funct3 == 3'b000);
  assign lh  = load_g && (funct3 == 3'b001);
  assign lw  = load_g && (funct3 == 3'b010);
  assign ld  = load_g && (funct3 == 3'b011);
  assign lbu = load_g && (funct3 == 3'b100);
  assign lhu = load_g && (funct3 == 3'b101);
  assign lwu = load_g && (funct3 == 3'b110);
  assign sb  = store_g && (funct3 == 3'b000);
  assign sh  = store_g && (funct3 == 3'b001);
  assign sw  = store_g && (funct3 == 3'b010);
  assign sd  = store_g && (funct3 == 3'b011);

  // write-back source selects
  assign wb_load = load_g;
  assign wb_pc   = jal_en | jalr_en;
  assign wb_alu  = lui_g | auipc_g | imm_op | imm_sh | reg_op | immw_op | immw_sh | regw_op;
  assign wb_en   = wb_load | wb_pc | wb_alu;

endmodule

/* design/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
  input  rv64_pkg::inst_t           inst,
  input  logic                      I_type,
  input  logic                      S_type,
  input  logic                      B_type,
  input  logic                      U_type,
  input  logic                      J_type,
  output logic [rv64_pkg::xlen-1:0] imm
);

  // the sign bit always sits in instruction bit 31, whatever the format
  always_comb begin
    if (I_type) begin
      imm = {{(rv64_pkg::xlen - 12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    end else if (S_type) begin
      imm = {{(rv64_pkg::xlen - 12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    end else if (B_type) begin
      imm = {{(rv64_pkg::xlen - 13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
             inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    end else if (U_type) begin
      // lui and auipc values are 32 bit and then widened
      imm = {{(rv64_pkg::xlen - rv64_pkg::ilen){inst.u.imm_31_12[19]}},
             inst.u.imm_31_12, 12'd0};
    end else if (J_type) begin
      imm = {{(rv64_pkg::xlen - 21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
             inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    end else begin
      imm = '0;  // R type and system carry no immediate
    end
  end

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [rv64_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv64_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv64_pkg::xlen-1:0]       rs1_data,
  output logic [rv64_pkg::xlen-1:0]       rs2_data,
  input  logic                            wr_en,
  input  logic [rv64_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv64_pkg::xlen-1:0]       wr_data
);

  logic [rv64_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k < 32; k++)
        regs[k] <= '0;
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // read with x0 forced to zero and the incoming write forwarded
  function automatic logic [rv64_pkg::xlen-1:0] read_port(
    input logic [rv64_pkg::reg_addr_w-1:0] addr
  );
    if (addr == '0)
      return '0;
    if (wr_en && (addr == wr_addr))
      return wr_data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  rv64_pkg::inst_t                 in_inst,
  input  logic [rv64_pkg::xlen-1:0]       in_pc,
  input  logic                            wr_en,
  input  logic [rv64_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [rv64_pkg::xlen-1:0]       wr_data,

  output logic                            out_valid,
  output logic [rv64_pkg::xlen-1:0]       out_pc,
  output logic                            wb_en,
  output logic                            wb_load,
  output logic                            wb_pc,
  output logic                            wb_alu,
  output logic                            I_type,
  output logic                            S_type,
  output logic                            B_type,
  output logic                            U_type,
  output logic                            J_type,
  output logic                            rs1_en,
  output logic                            rs2_en,
  output logic                            pc_en,
  output logic                            imm_en,
  output logic                            lgc_en,
  output logic [3:0]                      lgc_op,
  output logic                            wlgc_en,
  output logic [4:0]                      wlgc_op,
  output logic                            br_en,
  output logic [2:0]                      br_op,
  output logic                            jal_en,
  output logic                            jalr_en,
  output logic                            lb,
  output logic                            lh,
  output logic                            lw,
  output logic                            ld,
  output logic                            lbu,
  output logic                            lhu,
  output logic                            lwu,
  output logic                            sb,
  output logic                            sh,
  output logic                            sw,
  output logic                            sd,
  output logic                            ebreak,
  output logic [rv64_pkg::xlen-1:0]       out_imm,
  output logic [rv64_pkg::xlen-1:0]       out_rs1_data,
  output logic [rv64_pkg::xlen-1:0]       out_rs2_data
);

  logic                      d_wb_en, d_wb_load, d_wb_pc, d_wb_alu;
  logic                      d_i_type, d_s_type, d_b_type, d_u_type, d_j_type;
  logic                      d_rs1_en, d_rs2_en, d_pc_en, d_imm_en;
  logic                      d_lgc_en, d_wlgc_en, d_br_en, d_jal_en, d_jalr_en;
  logic [3:0]                d_lgc_op;
  logic [4:0]                d_wlgc_op;
  logic [2:0]                d_br_op;
  logic                      d_lb, d_lh, d_lw, d_ld, d_lbu, d_lhu, d_lwu;
  logic                      d_sb, d_sh, d_sw, d_sd, d_ebreak;
  logic [rv64_pkg::xlen-1:0] d_imm;
  logic [rv64_pkg::xlen-1:0] d_rs1_data;
  logic [rv64_pkg::xlen-1:0] d_rs2_data;
  logic [rv64_pkg::ctrl_w-1:0] ctrl_d;
  logic [rv64_pkg::ctrl_w-1:0] ctrl_q;

  inst_decoder i_inst_decoder (
    .inst    (in_inst),
    .wb_en   (d_wb_en),   .wb_load (d_wb_load), .wb_pc   (d_wb_pc),   .wb_alu  (d_wb_alu),
    .I_type  (d_i_type),  .S_type  (d_s_type),  .B_type  (d_b_type),
    .U_type  (d_u_type),  .J_type  (d_j_type),
    .rs1_en  (d_rs1_en),  .rs2_en  (d_rs2_en),  .pc_en   (d_pc_en),   .imm_en  (d_imm_en),
    .lgc_en  (d_lgc_en),  .lgc_op  (d_lgc_op),  .wlgc_en (d_wlgc_en), .wlgc_op (d_wlgc_op),
    .br_en   (d_br_en),   .br_op   (d_br_op),   .jal_en  (d_jal_en),  .jalr_en (d_jalr_en),
    .lb      (d_lb),      .lh      (d_lh),      .lw      (d_lw),      .ld      (d_ld),
    .lbu     (d_lbu),     .lhu     (d_lhu),     .lwu     (d_lwu),
    .sb      (d_sb),      .sh      (d_sh),      .sw      (d_sw),      .sd      (d_sd),
    .ebreak  (d_ebreak)
  );

  imm_gen i_imm_gen (
    .inst   (in_inst),
    .I_type (d_i_type),
    .S_type (d_s_type),
    .B_type (d_b_type),
    .U_type (d_u_type),
    .J_type (d_j_type),
    .imm    (d_imm)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (in_inst.r.rs1),
    .rs2_addr (in_inst.r.rs2),
    .rs1_data (d_rs1_data),
    .rs2_data (d_rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  // ####################################################################
  // decode/execute pipeline register
  // ####################################################################

  assign ctrl_d = {d_wb_en, d_wb_load, d_wb_pc, d_wb_alu,
                   d_i_type, d_s_type, d_b_type, d_u_type, d_j_type,
                   d_rs1_en, d_rs2_en, d_pc_en, d_imm_en,
                   d_lgc_en, d_lgc_op, d_wlgc_en, d_wlgc_op, d_br_en, d_br_op,
                   d_jal_en, d_jalr_en,
                   d_lb, d_lh, d_lw, d_ld, d_lbu, d_lhu, d_lwu,
                   d_sb, d_sh, d_sw, d_sd, d_ebreak};

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      ctrl_q    <= '0;
    end else begin
      out_valid <= in_valid;
      ctrl_q    <= in_valid ? ctrl_d : '0;  // a bubble carries no strobes
    end
  end

  always_ff @(posedge clk) begin
    out_pc       <= in_pc;
    out_imm      <= d_imm;
    out_rs1_data <= d_rs1_data;
    out_rs2_data <= d_rs2_data;
  end

  assign {wb_en, wb_load, wb_pc, wb_alu,
          I_type, S_type, B_type, U_type, J_type,
          rs1_en, rs2_en, pc_en, imm_en,
          lgc_en, lgc_op, wlgc_en, wlgc_op, br_en, br_op,
          jal_en, jalr_en,
          lb, lh, lw, ld, lbu, lhu, lwu,
          sb, sh, sw, sd, ebreak} = ctrl_q;

endmodule

/* sim/decode_assert.sv */
`timescale 1ns/100ps

module decode_assert (
  input logic clk,
  input logic rst,
  input logic out_valid,
  input logic I_type, S_type, B_type, U_type, J_type,
  input logic lb, lh, lw, ld, lbu, lhu, lwu, sb, sh, sw, sd
);

  int fails = 0;

  valid_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $error("out_valid is set in the cycle after reset");
      fails++;
    end

  single_format: assert property (@(posedge clk) disable iff (rst)
    $onehot0({I_type, S_type, B_type, U_type, J_type}))
    else begin
      $error("more than one format flag is set");
      fails++;
    end

  single_width: assert property (@(posedge clk) disable iff (rst)
    $onehot0({lb, lh, lw, ld, lbu, lhu, lwu, sb, sh, sw, sd}))
    else begin
      $error("more than one load or store width strobe is set");
      fails++;
    end

endmodule

bind decode_stage decode_assert i_decode_assert (.*);

/* sim/decode_model.svh */
`ifndef decode_model_svh
`define decode_model_svh

// control word order: wb selects, formats, operand enables, lgc, wlgc, branch,
// jumps, load widths, store widths, ebreak
function automatic logic [41:0] expected_ctrl(input rv64_pkg::inst_t inst);
  logic [2:0]  f3;
  logic        b30;
  logic [17:0] fixed;  // wb(4) fmt(5) operands(4) lgc_en wlgc_en br_en jal jalr
  logic [3:0]  lgc_op;
  logic [4:0]  wlgc_op;
  logic [6:0]  loads;
  logic [3:0]  stores;
  logic        brk;
  f3 = inst.r.funct3;
  b30 = inst.r.funct7[5];
  lgc_op = 4'd0;
  wlgc_op = 5'd0;
  loads = 7'd0;
  stores = 4'd0;
  case (inst.r.opcode[6:2])
    rv64_pkg::op_load:   fixed = 18'b1100_10000_1001_1_0_0_00;
    rv64_pkg::op_store:  fixed = 18'b0000_01000_1101_1_0_0_00;
    rv64_pkg::op_imm:    fixed = 18'b1001_10000_1001_1_0_0_00;
    rv64_pkg::op_imm_w:  fixed = 18'b1001_10000_1001_0_1_0_00;
    rv64_pkg::op_reg:    fixed = 18'b1001_00000_1100_1_0_0_00;
    rv64_pkg::op_reg_w:  fixed = 18'b1001_00000_1100_0_1_0_00;
    rv64_pkg::op_lui:    fixed = 18'b1001_00010_0001_1_0_0_00;
    rv64_pkg::op_auipc:  fixed = 18'b1001_00010_0011_1_0_0_00;
    rv64_pkg::op_jal:    fixed = 18'b1010_00001_0011_1_0_0_10;
    rv64_pkg::op_jalr:   fixed = 18'b1010_10000_1001_1_0_0_01;
    rv64_pkg::op_branch: fixed = 18'b0000_00100_1100_0_0_1_00;
    default:             fixed = 18'd0;
  endcase
  // shifts are funct3 x01 and keep bit 30 as the arithmetic flag
  case (inst.r.opcode[6:2])
    rv64_pkg::op_lui:   lgc_op = 4'b1111;
    rv64_pkg::op_reg:   lgc_op = {b30, f3};
    rv64_pkg::op_imm:   lgc_op = (f3[1:0] == 2'b01) ? {b30, f3} : {1'b0, f3};
    rv64_pkg::op_reg_w: wlgc_op = {1'b1, b30, f3};
    rv64_pkg::op_imm_w: wlgc_op = (f3[1:0] == 2'b01) ? {1'b1, b30, f3} : {2'b10, f3};
    rv64_pkg::op_load:  loads = (f3 == 3'b111) ? 7'd0 : 7'b1000000 >> f3;
    rv64_pkg::op_store: stores = f3[2] ? 4'd0 : 4'b1000 >> f3;
    default: ;
  endcase
  brk = (inst.r.opcode[6:2] == rv64_pkg::op_system) && (inst.r.funct7 == 7'd0) &&
        (inst.r.rs2 == 5'd1);
  return {fixed[17:5], fixed[4], lgc_op, fixed[3], wlgc_op, fixed[2], f3, fixed[1:0],
          loads, stores, brk};
endfunction

function automatic logic [63:0] expected_imm(input logic [31:0] w);
  case (w[6:2])
    rv64_pkg::op_load, rv64_pkg::op_imm, rv64_pkg::op_imm_w, rv64_pkg::op_jalr:
      return {{52{w[31]}}, w[31:20]};
    rv64_pkg::op_store:  return {{52{w[31]}}, w[31:25], w[11:7]};
    rv64_pkg::op_branch: return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    rv64_pkg::op_lui, rv64_pkg::op_auipc: return {{32{w[31]}}, w[31:12], 12'd0};
    rv64_pkg::op_jal:    return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    default:             return 64'd0;
  endcase
endfunction

`endif

/* sim/tb_decode_stage.sv */
`timescale 1ns/100ps

module tb_decode_stage;

  localparam int test_cycles = 5 + 400 + 120 + 150 + 60 + 80 + 60 + 7;  // flushes included

  logic clk, rst, in_valid, wr_en;
  rv64_pkg::inst_t in_inst;
  logic [63:0] in_pc, wr_data, out_pc, out_imm, out_rs1_data, out_rs2_data;
  logic [4:0] wr_addr;
  logic out_valid, wb_en, wb_load, wb_pc, wb_alu, I_type, S_type, B_type, U_type, J_type;
  logic rs1_en, rs2_en, pc_en, imm_en, lgc_en, wlgc_en, br_en, jal_en, jalr_en, ebreak;
  logic [3:0] lgc_op;
  logic [4:0] wlgc_op;
  logic [2:0] br_op;
  logic lb, lh, lw, ld, lbu, lhu, lwu, sb, sh, sw, sd;

  logic [31:0] lfsr = 32'h4b3e;
  logic [63:0] shadow [32];
  logic exp_valid;
  logic [63:0] exp_ctrl, exp_imm, exp_pc, exp_rs1, exp_rs2;
  int errors, tests_passed, tests_failed;

  string field_name [33] = '{"wb_en", "wb_load", "wb_pc", "wb_alu", "I_type", "S_type",
    "B_type", "U_type", "J_type", "rs1_en", "rs2_en", "pc_en", "imm_en", "lgc_en", "lgc_op",
    "wlgc_en", "wlgc_op", "br_en", "br_op", "jal_en", "jalr_en", "lb", "lh", "lw", "ld",
    "lbu", "lhu", "lwu", "sb", "sh", "sw", "sd", "ebreak"};
  int field_width [33] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 4, 1, 5, 1, 3, 1, 1,
    1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1};
  logic [4:0] opcode_list [12] = '{rv64_pkg::op_load, rv64_pkg::op_store, rv64_pkg::op_imm,
    rv64_pkg::op_imm_w, rv64_pkg::op_reg, rv64_pkg::op_reg_w, rv64_pkg::op_lui,
    rv64_pkg::op_auipc, rv64_pkg::op_jal, rv64_pkg::op_jalr, rv64_pkg::op_branch,
    rv64_pkg::op_system};

  decode_stage i_decode_stage (.*);

  `include "decode_model.svh"

  initial clk = 1'b0;
  always #4 clk = ~clk;

  initial begin
    #(test_cycles * 8 * 2);
    $display("timeout: the tests did not finish in the expected time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // ####################################################################
  // random numbers and stimulus helpers
  // ####################################################################

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = 64'd0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [4:0] random_opcode();
    logic [63:0] k;
    do k = rand_bits(4); while (k >= 64'd12);
    return opcode_list[k[3:0]];
  endfunction

  function automatic logic [31:0] random_inst(input logic [4:0] op);
    logic [63:0] f;
    f = rand_bits(25);
    return {f[24:0], op, 2'b11};
  endfunction

  // x0 wins over the bypass, the bypass wins over the stored value
  function automatic logic [63:0] read_shadow(input logic [4:0] addr, input logic wen,
                                              input logic [4:0] waddr, input logic [63:0] wdata);
    if (addr == 5'd0)
      return 64'd0;
    if (wen && (addr == waddr))
      return wdata;
    return shadow[addr];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
    else begin
      $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_outputs();
    logic [63:0] act;
    logic [63:0] mask;
    int pos;
    act = 64'({wb_en, wb_load, wb_pc, wb_alu, I_type, S_type, B_type, U_type, J_type,
               rs1_en, rs2_en, pc_en, imm_en, lgc_en, lgc_op, wlgc_en, wlgc_op, br_en, br_op,
               jal_en, jalr_en, lb, lh, lw, ld, lbu, lhu, lwu, sb, sh, sw, sd, ebreak});
    check_value("out_valid", 64'(exp_valid), 64'(out_valid));
    pos = 42;
    for (int f = 0; f < 33; f++) begin
      pos -= field_width[f];
      mask = (64'd1 << field_width[f]) - 64'd1;
      check_value(field_name[f], (exp_ctrl >> pos) & mask, (act >> pos) & mask);
    end
    if (exp_valid) begin  // data fields are don't care behind a bubble
      check_value("out_pc", exp_pc, out_pc);
      check_value("out_imm", exp_imm, out_imm);
      check_value("out_rs1_data", exp_rs1, out_rs1_data);
      check_value("out_rs2_data", exp_rs2, out_rs2_data);
    end
  endtask

  // drive one cycle, check the result of the previous one, then predict this one
  task automatic drive_cycle(input logic valid, input logic [31:0] word, input logic wen,
                             input logic [4:0] waddr, input logic [63:0] wdata);
    logic [63:0] r;
    r = rand_bits(62);
    @(posedge clk);
    in_valid <= valid;
    in_inst  <= word;
    in_pc    <= {r[61:0], 2'b00};
    wr_en    <= wen;
    wr_addr  <= waddr;
    wr_data  <= wdata;
    @(negedge clk);
    check_outputs();
    exp_valid = valid;
    exp_ctrl  = valid ? 64'(expected_ctrl(word)) : 64'd0;
    exp_imm   = expected_imm(word);
    exp_pc    = {r[61:0], 2'b00};
    exp_rs1   = read_shadow(word[19:15], wen, waddr, wdata);
    exp_rs2   = read_shadow(word[24:20], wen, waddr, wdata);
    if (wen && (waddr != 5'd0))
      shadow[waddr] = wdata;
  endtask

  task automatic report_test(input string name, input int mark);
    drive_cycle(1'b0, 32'd0, 1'b0, 5'd0, 64'd0);  // lets the last result reach a check
    if (errors == mark) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - mark);
    end
  endtask

  // ####################################################################
  // test sequence
  // ####################################################################

  initial begin
    int mark;
    logic [31:0] w;
    logic [63:0] r;
    rst = 1'b1;
    in_valid = 1'b0;
    in_inst = '0;
    in_pc = 64'd0;
    wr_en = 1'b0;
    wr_addr = 5'd0;
    wr_data = 64'd0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    exp_valid = 1'b0;
    exp_ctrl = 64'd0;
    foreach (shadow[k])
      shadow[k] = 64'd0;

    mark = errors;
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      in_valid <= (c < 4);  // reset must win over a valid instruction
      in_inst  <= random_inst(random_opcode());
      rst      <= (c < 4);
      @(negedge clk);
      check_outputs();
    end
    report_test("reset", mark);

    mark = errors;
    repeat (400) drive_cycle(1'b1, random_inst(random_opcode()), 1'b0, 5'd0, 64'd0);
    report_test("controls", mark);

    mark = errors;
    for (int n = 0; n < 120; n++)
      drive_cycle(1'b1, random_inst(opcode_list[n % 12]), 1'b0, 5'd0, 64'd0);
    report_test("immediates", mark);

    mark = errors;
    w = {17'd0, 3'd0, 5'd1, rv64_pkg::op_reg, 2'b11};  // add x1, x0, x0
    drive_cycle(1'b1, w, 1'b1, 5'd0, 64'hdead_beef_0bad_f00d);
    drive_cycle(1'b1, w, 1'b0, 5'd0, 64'd0);
    for (int n = 0; n < 148; n++) begin
      r = rand_bits(7);
      drive_cycle(1'b1, random_inst(rv64_pkg::op_reg), r[6] | r[5], r[4:0], rand_bits(64));
    end
    report_test("register file", mark);

    mark = errors;
    for (int n = 0; n < 60; n++) begin
      w = random_inst(n[0] ? rv64_pkg::op_store : rv64_pkg::op_reg);
      r = rand_bits(1);
      drive_cycle(1'b1, w, 1'b1, r[0] ? w[24:20] : w[19:15], rand_bits(64));
    end
    report_test("bypass", mark);

    mark = errors;
    for (int n = 0; n < 80; n++) begin
      r = rand_bits(1);
      drive_cycle(r[0], random_inst(random_opcode()), 1'b0, 5'd0, 64'd0);
    end
    report_test("valid", mark);

    mark = errors;
    drive_cycle(1'b1, 32'h0010_0073, 1'b0, 5'd0, 64'd0);
    for (int n = 0; n < 59; n++) begin
      r = rand_bits(12);
      drive_cycle(1'b1, {r[11:5], r[4:0], 13'd0, 7'b1110011}, 1'b0, 5'd0, 64'd0);
    end
    report_test("ebreak", mark);

    $display("tests passed %0d, tests failed %0d, assertion failures %0d",
             tests_passed, tests_failed, i_decode_stage.i_decode_assert.fails);
    if (tests_failed == 0 && i_decode_stage.i_decode_assert.fails == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* rv64_decode.f */
+incdir+sim
common/rv64_pkg.sv
decoder/inst_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/decode_stage.sv
sim/decode_assert.sv
sim/tb_decode_stage.sv

/* Bender.yml */
package:
  name: rv64_decode

sources:
  - common/rv64_pkg.sv
  - decoder/inst_decoder.sv
  - design/imm_gen.sv
  - design/reg_file.sv
  - design/decode_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/decode_assert.sv
      - sim/tb_decode_stage.sv
